// File: sim.f
hw/core_pkg.sv
hw/save_data_loader.sv
hw/save_data_unloader.sv
hw/save_buffer.sv
hw/video_sync_conditioner.sv
hw/core_top.sv
tb/core_top_assert.sv
tb/tb_core_top.sv

// File: Makefile
# Verilator build and run for tb_core_top

.PHONY: run clean

run: obj_dir/Vtb_core_top
	obj_dir/Vtb_core_top | tee sim.log
	grep -q "^all tests passed$$" sim.log

obj_dir/Vtb_core_top: sim.f $(wildcard hw/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing --assert --top-module tb_core_top -f sim.f

clean:
	rm -rf obj_dir sim.log

// File: tb/tb_core_top.sv
////////////////////////////////////////
// Directed tests for core_top with default parameters.
// Bridge reads sample bridge_rd_data 6 cycles after the request.
////////////////////////////////////////

`timescale 1ns/1ps

module tb_core_top;

  import core_pkg::*;

  localparam int NUM_TESTS   = 6;
  localparam int WATCHDOG_NS = NUM_TESTS * 400 * 8;
  localparam int NUM_WORDS   = 16;

  logic         clk_74a;
  logic         pll_core_locked;
  bridge_word_t bridge_addr;
  logic         bridge_wr;
  bridge_word_t bridge_wr_data;
  logic         bridge_rd;
  bridge_word_t bridge_rd_data;
  logic         h_blank;
  logic         v_blank;
  logic         hs_in;
  logic         vs_in;
  rgb_t         rgb_in;
  logic         video_de;
  logic         video_hs;
  logic         video_vs;
  rgb_t         video_rgb;

  integer       seed = 58;
  int           errors = 0;
  int           tests_failed = 0;
  int           start_errors = 0;
  bridge_word_t written [0:NUM_WORDS-1];

  core_top UUT (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd      (bridge_rd),
    .bridge_rd_data (bridge_rd_data),
    .h_blank        (h_blank),
    .v_blank        (v_blank),
    .hs_in          (hs_in),
    .vs_in          (vs_in),
    .rgb_in         (rgb_in),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs),
    .video_rgb      (video_rgb)
  );

  initial begin
    clk_74a = 1'b0;
    forever #4 clk_74a = ~clk_74a;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, a test did not finish", WATCHDOG_NS);
    $display("tests failed");
    $finish;
  end

  ////////////////////////////////////////
  // compare and report
  ////////////////////////////////////////

  task automatic check_word(input string name, input bridge_word_t expected,
                            input bridge_word_t actual);
    if (actual !== expected) begin
      errors = errors + 1;
      $display("MISMATCH %s expected %08h actual %08h", name, expected, actual);
    end
  endtask

  task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
    if (actual !== expected) begin
      errors = errors + 1;
      $display("MISMATCH %s expected %06h actual %06h", name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      errors = errors + 1;
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic mark_test_start();
    start_errors = errors;
  endtask

  task automatic report_test(input string name);
    if (errors == start_errors) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("test %s: %0d errors", name, errors - start_errors);
    end
  endtask

  ////////////////////////////////////////
  // bridge access
  ////////////////////////////////////////

  function automatic bridge_word_t region_addr(input logic [3:0] region, input int word);
    return {region, 28'(word * BYTES_PER_WORD)};
  endfunction

  task automatic bridge_write(input bridge_word_t addr, input bridge_word_t data);
    @(posedge clk_74a);
    bridge_addr    <= addr;
    bridge_wr_data <= data;
    bridge_wr      <= 1'b1;
    @(posedge clk_74a);
    bridge_wr <= 1'b0;
    // keeps the next request 8 or more cycles away
    repeat (7) @(posedge clk_74a);
  endtask

  task automatic bridge_read(input bridge_word_t addr, output bridge_word_t data);
    @(posedge clk_74a);
    bridge_addr <= addr;
    bridge_rd   <= 1'b1;
    @(posedge clk_74a);
    bridge_rd <= 1'b0;
    // word is held from cycle 6 on
    repeat (6) @(posedge clk_74a);
    @(negedge clk_74a);
    data = bridge_rd_data;
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic check_outputs_quiet();
    check_word("bridge_rd_data", '0, bridge_rd_data);
    check_bit("video_de", 1'b0, video_de);
    check_bit("video_hs", 1'b0, video_hs);
    check_bit("video_vs", 1'b0, video_vs);
    check_rgb("video_rgb", '0, video_rgb);
  endtask

  task automatic reset_state();
    mark_test_start();
    @(posedge clk_74a);
    @(negedge clk_74a);
    check_outputs_quiet();
    // third rising edge still sees reset
    repeat (2) @(posedge clk_74a);
    pll_core_locked <= 1'b1;
    // one active edge with blanking and no sync
    @(posedge clk_74a);
    @(negedge clk_74a);
    check_outputs_quiet();
    report_test("reset state");
  endtask

  task automatic write_then_read();
    bridge_word_t rd;
    mark_test_start();
    for (int i = 0; i < NUM_WORDS; i++) begin
      written[i] = $random(seed);
      bridge_write(region_addr(SAVE_REGION, i), written[i]);
    end
    for (int i = 0; i < NUM_WORDS; i++) begin
      bridge_read(region_addr(SAVE_REGION, i), rd);
      check_word("bridge_rd_data", written[i], rd);
    end
    report_test("write then read");
  endtask

  task automatic region_decode();
    bridge_word_t rd;
    mark_test_start();
    bridge_read(region_addr(4'h1, 3), rd);
    check_word("bridge_rd_data", '0, rd);
    bridge_write(region_addr(4'h1, 3), ~written[3]);
    bridge_read(region_addr(SAVE_REGION, 3), rd);
    check_word("bridge_rd_data", written[3], rd);
    report_test("region decode");
  endtask

  task automatic overwrite_word();
    bridge_word_t rd;
    bridge_word_t fresh;
    mark_test_start();
    fresh = $random(seed);
    bridge_write(region_addr(SAVE_REGION, 5), fresh);
    bridge_read(region_addr(SAVE_REGION, 5), rd);
    check_word("bridge_rd_data", fresh, rd);
    // neighbors keep their old words
    bridge_read(region_addr(SAVE_REGION, 4), rd);
    check_word("bridge_rd_data", written[4], rd);
    bridge_read(region_addr(SAVE_REGION, 6), rd);
    check_word("bridge_rd_data", written[6], rd);
    report_test("overwrite");
  endtask

  task automatic de_rgb_gating();
    logic [31:0] r;
    logic        blank;
    mark_test_start();
    for (int i = 0; i < 40; i++) begin
      r = $random(seed);
      blank = r[31] || r[30];
      @(posedge clk_74a);
      h_blank <= r[31];
      v_blank <= r[30];
      rgb_in  <= r[23:0];
      @(posedge clk_74a);
      @(negedge clk_74a);
      check_bit("video_de", !blank, video_de);
      check_rgb("video_rgb", blank ? rgb_t'(0) : rgb_t'(r[23:0]), video_rgb);
    end
    report_test("de and rgb gating");
  endtask

  task automatic sync_pulses();
    mark_test_start();
    @(posedge clk_74a);
    vs_in <= 1'b1;
    // k counts rising edges from the one that first samples the input high
    for (int k = 0; k < 12; k++) begin
      @(posedge clk_74a);
      if (k == 4) begin
        vs_in <= 1'b0;
      end
      @(negedge clk_74a);
      check_bit("video_vs", k == 0, video_vs);
      check_bit("video_hs", 1'b0, video_hs);
    end
    @(posedge clk_74a);
    hs_in <= 1'b1;
    for (int k = 0; k < 16; k++) begin
      @(posedge clk_74a);
      if (k == 3) begin
        hs_in <= 1'b0;
      end
      @(negedge clk_74a);
      check_bit("video_hs", k == DEF_HS_DELAY, video_hs);
      check_bit("video_vs", 1'b0, video_vs);
    end
    report_test("sync pulses");
  endtask

  initial begin
    pll_core_locked <= 1'b0;
    bridge_addr     <= {SAVE_REGION, 28'h0};
    bridge_wr       <= 1'b0;
    bridge_wr_data  <= '0;
    bridge_rd       <= 1'b0;
    h_blank         <= 1'b1;
    v_blank         <= 1'b1;
    hs_in           <= 1'b0;
    vs_in           <= 1'b0;
    rgb_in          <= '0;

    reset_state();
    write_then_read();
    region_decode();
    overwrite_word();
    de_rgb_gating();
    sync_pulses();

    $display("%0d of %0d tests failed, %0d mismatches, %0d assertion failures",
             tests_failed, NUM_TESTS, errors, UUT.u_assert.fails);
    if (errors == 0 && UUT.u_assert.fails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: tb/core_top_assert.sv
////////////////////////////////////////
// Bound checks on core_top: bridge spacing, sync pulse width
// and RGB blanking. Inactive while pll_core_locked is low.
////////////////////////////////////////

`timescale 1ns/1ps

module core_top_assert (
  input logic           clk_74a,
  input logic           pll_core_locked,
  input logic           bridge_wr,
  input logic           bridge_rd,
  input logic           video_de,
  input logic           video_hs,
  input logic           video_vs,
  input core_pkg::rgb_t video_rgb
);

  logic [2:0] gap_q;
  logic       access;

  // failed assertion count, read by the testbench summary
  int         fails = 0;

  assign access = bridge_wr || bridge_rd;

  // cycles since the last bridge access, saturates at 7
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      gap_q <= 3'd7;
    end else if (access) begin
      gap_q <= '0;
    end else if (gap_q != 3'd7) begin
      gap_q <= gap_q + 3'd1;
    end
  end

  bridge_spacing: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    access |-> gap_q == 3'd7)
    else begin
      fails = fails + 1;
      $error("bridge access less than 8 cycles after the previous one");
    end

  hs_single: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_hs |=> !video_hs)
    else begin
      fails = fails + 1;
      $error("video_hs high for more than one cycle");
    end

  vs_single: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_vs |=> !video_vs)
    else begin
      fails = fails + 1;
      $error("video_vs high for more than one cycle");
    end

  rgb_blanked: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    !video_de |-> video_rgb == '0)
    else begin
      fails = fails + 1;
      $error("video_rgb not zero while video_de is low");
    end

endmodule

bind core_top core_top_assert u_assert (
  .clk_74a        (clk_74a),
  .pll_core_locked(pll_core_locked),
  .bridge_wr      (bridge_wr),
  .bridge_rd      (bridge_rd),
  .video_de       (video_de),
  .video_hs       (video_hs),
  .video_vs       (video_vs),
  .video_rgb      (video_rgb)
);

// File: hw/core_top.sv
////////////////////////////////////////
// Save-data bridge path and video sync path, all on clk_74a.
// Bridge accesses must be at least 8 cycles apart.
// Reset is pll_core_locked, active low.
////////////////////////////////////////

`timescale 1ns/1ps

module core_top #(
  parameter int save_addr_bits = core_pkg::DEF_SAVE_ADDR_BITS,
  parameter int hs_delay       = core_pkg::DEF_HS_DELAY
) (
  input  logic                   clk_74a,
  input  logic                   pll_core_locked,

  // bridge, big-endian
  input  core_pkg::bridge_word_t bridge_addr,
  input  logic                   bridge_wr,
  input  core_pkg::bridge_word_t bridge_wr_data,
  input  logic                   bridge_rd,
  output core_pkg::bridge_word_t bridge_rd_data,

  // raw video from the core
  input  logic                   h_blank,
  input  logic                   v_blank,
  input  logic                   hs_in,
  input  logic                   vs_in,
  input  core_pkg::rgb_t         rgb_in,

  // scaler video
  output logic                   video_de,
  output logic                   video_hs,
  output logic                   video_vs,
  output core_pkg::rgb_t         video_rgb
);

  import core_pkg::*;

  logic                      sd_wr_en;
  logic [save_addr_bits-1:0] sd_wr_addr;
  save_byte_t                sd_wr_data;
  logic                      sd_rd_en;
  logic [save_addr_bits-1:0] sd_rd_addr;
  save_byte_t                sd_rd_data;

  ////////////////////////////////////////
  // save data
  ////////////////////////////////////////

  save_data_loader #(
    .save_addr_bits(save_addr_bits)
  ) u_loader (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .wr_en          (sd_wr_en),
    .wr_addr        (sd_wr_addr),
    .wr_data        (sd_wr_data)
  );

  save_data_unloader #(
    .save_addr_bits(save_addr_bits)
  ) u_unloader (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_rd      (bridge_rd),
    .bridge_rd_data (bridge_rd_data),
    .rd_en          (sd_rd_en),
    .rd_addr        (sd_rd_addr),
    .rd_data        (sd_rd_data)
  );

  save_buffer #(
    .save_addr_bits(save_addr_bits)
  ) u_buffer (
    .clk_74a(clk_74a),
    .wr_en  (sd_wr_en),
    .wr_addr(sd_wr_addr),
    .wr_data(sd_wr_data),
    .rd_en  (sd_rd_en),
    .rd_addr(sd_rd_addr),
    .rd_data(sd_rd_data)
  );

  ////////////////////////////////////////
  // video
  ////////////////////////////////////////

  video_sync_conditioner #(
    .hs_delay(hs_delay)
  ) u_video (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .h_blank        (h_blank),
    .v_blank        (v_blank),
    .hs_in          (hs_in),
    .vs_in          (vs_in),
    .rgb_in         (rgb_in),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs),
    .video_rgb      (video_rgb)
  );

endmodule

// File: hw/video_sync_conditioner.sv
////////////////////////////////////////
// Turns raw core sync and blank into scaler video outputs.
// All outputs are registered, one cycle of latency.
// hs_delay must be 1 or more.
////////////////////////////////////////

`timescale 1ns/1ps

module video_sync_conditioner #(
  parameter int hs_delay = core_pkg::DEF_HS_DELAY
) (
  input  logic           clk_74a,
  input  logic           pll_core_locked,
  input  logic           h_blank,
  input  logic           v_blank,
  input  logic           hs_in,
  input  logic           vs_in,
  input  core_pkg::rgb_t rgb_in,
  output logic           video_de,
  output logic           video_hs,
  output logic           video_vs,
  output core_pkg::rgb_t video_rgb
);

  localparam int CNT_W = $clog2(hs_delay + 1);

  logic             hs_prev_q;
  logic             vs_prev_q;
  logic [CNT_W-1:0] hs_cnt_q;
  logic             active;

  assign active = !(h_blank || v_blank);

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_de  <= 1'b0;
      video_rgb <= '0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      hs_prev_q <= 1'b0;
      vs_prev_q <= 1'b0;
      hs_cnt_q  <= '0;
    end else begin
      video_de  <= active;
      video_rgb <= active ? rgb_in : '0;

      // single cycle vsync on the rising edge
      video_vs  <= vs_in && !vs_prev_q;

      // hsync pulse delayed so it never lands on top of vsync
      video_hs  <= (hs_cnt_q == CNT_W'(1));
      if (hs_in && !hs_prev_q) begin
        // a new edge restarts the count
        hs_cnt_q <= CNT_W'(hs_delay);
      end else if (hs_cnt_q != '0) begin
        hs_cnt_q <= hs_cnt_q - CNT_W'(1);
      end

      hs_prev_q <= hs_in;
      vs_prev_q <= vs_in;
    end
  end

endmodule

// File: hw/save_buffer.sv
////////////////////////////////////////
// Byte RAM for save data, one write and one read port.
// Read data appears one cycle after rd_en. Contents power up unknown.
////////////////////////////////////////

`timescale 1ns/1ps

module save_buffer #(
  parameter int save_addr_bits = core_pkg::DEF_SAVE_ADDR_BITS
) (
  input  logic                      clk_74a,
  input  logic                      wr_en,
  input  logic [save_addr_bits-1:0] wr_addr,
  input  core_pkg::save_byte_t      wr_data,
  input  logic                      rd_en,
  input  logic [save_addr_bits-1:0] rd_addr,
  output core_pkg::save_byte_t      rd_data
);

  import core_pkg::*;

  save_byte_t mem [0:(1 << save_addr_bits) - 1];

  always_ff @(posedge clk_74a) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read port
  always_ff @(posedge clk_74a) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// File: hw/save_data_unloader.sv
////////////////////////////////////////
// Gathers four bytes from the save buffer into one bridge word.
// Result is valid by cycle 6 after bridge_rd and held until the next read.
// bridge_rd_data is zero outside the save region.
////////////////////////////////////////

`timescale 1ns/1ps

module save_data_unloader #(
  parameter int save_addr_bits = core_pkg::DEF_SAVE_ADDR_BITS
) (
  input  logic                      clk_74a,
  input  logic                      pll_core_locked,
  input  core_pkg::bridge_word_t    bridge_addr,
  input  logic                      bridge_rd,
  output core_pkg::bridge_word_t    bridge_rd_data,
  output logic                      rd_en,
  output logic [save_addr_bits-1:0] rd_addr,
  input  core_pkg::save_byte_t      rd_data
);

  import core_pkg::*;

  logic                              busy_q;
  logic [1:0]                        byte_cnt_q;
  logic [save_addr_bits-3:0]         word_off_q;
  logic                              rd_valid_q;
  logic                              rd_last_q;
  logic [(BYTES_PER_WORD-1)*8-1:0]   asm_q;
  bridge_word_t                      hold_q;
  logic                              in_region;
  logic                              rd_req;

  assign in_region = (bridge_addr[31:28] == SAVE_REGION);
  assign rd_req    = bridge_rd && in_region && !busy_q;

  ////////////////////////////////////////
  // read issue, cycles 1 to 4
  ////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      busy_q     <= 1'b0;
      byte_cnt_q <= '0;
      rd_valid_q <= 1'b0;
      rd_last_q  <= 1'b0;
    end else begin
      // buffer answers one cycle after rd_en
      rd_valid_q <= busy_q;
      rd_last_q  <= busy_q && (byte_cnt_q == 2'(BYTES_PER_WORD - 1));
      if (rd_req) begin
        busy_q     <= 1'b1;
        byte_cnt_q <= '0;
      end else if (busy_q) begin
        byte_cnt_q <= byte_cnt_q + 2'd1;
        if (byte_cnt_q == 2'(BYTES_PER_WORD - 1)) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_74a) begin
    if (rd_req) begin
      word_off_q <= bridge_addr[save_addr_bits-1:2];
    end
    // first byte returned ends up in the top bits
    if (rd_valid_q) begin
      asm_q <= {asm_q[(BYTES_PER_WORD-2)*8-1:0], rd_data};
    end
  end

  ////////////////////////////////////////
  // completed word
  ////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_q <= '0;
    end else if (rd_valid_q && rd_last_q) begin
      hold_q <= {asm_q, rd_data};
    end
  end

  assign rd_en          = busy_q;
  assign rd_addr        = {word_off_q, byte_cnt_q};
  // plain read mux, follows bridge_addr without a register
  assign bridge_rd_data = in_region ? hold_q : '0;

endmodule

// File: hw/save_data_loader.sv
////////////////////////////////////////
// Splits a save-region bridge write into four byte writes,
// most significant byte first, in the four cycles after the request.
// Requests arriving while busy are dropped; there is no back-pressure.
////////////////////////////////////////

`timescale 1ns/1ps

module save_data_loader #(
  parameter int save_addr_bits = core_pkg::DEF_SAVE_ADDR_BITS
) (
  input  logic                      clk_74a,
  input  logic                      pll_core_locked,
  input  core_pkg::bridge_word_t    bridge_addr,
  input  logic                      bridge_wr,
  input  core_pkg::bridge_word_t    bridge_wr_data,
  output logic                      wr_en,
  output logic [save_addr_bits-1:0] wr_addr,
  output core_pkg::save_byte_t      wr_data
);

  import core_pkg::*;

  logic                      busy_q;
  logic [1:0]                byte_cnt_q;
  logic [save_addr_bits-3:0] word_off_q;
  bridge_word_t              word_q;
  logic                      wr_req;

  // save region hit, only accepted when idle
  assign wr_req = bridge_wr && (bridge_addr[31:28] == SAVE_REGION) && !busy_q;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      busy_q     <= 1'b0;
      byte_cnt_q <= '0;
    end else if (wr_req) begin
      busy_q     <= 1'b1;
      byte_cnt_q <= '0;
    end else if (busy_q) begin
      byte_cnt_q <= byte_cnt_q + 2'd1;
      // fourth byte goes out this cycle
      if (byte_cnt_q == 2'(BYTES_PER_WORD - 1)) begin
        busy_q <= 1'b0;
      end
    end
  end

  // word shifts left so the next byte always sits in the top bits
  always_ff @(posedge clk_74a) begin
    if (wr_req) begin
      word_q     <= bridge_wr_data;
      word_off_q <= bridge_addr[save_addr_bits-1:2];
    end else if (busy_q) begin
      word_q <= word_q << 8;
    end
  end

  assign wr_en   = busy_q;
  assign wr_addr = {word_off_q, byte_cnt_q};
  assign wr_data = word_q[31:24];

endmodule

// File: hw/core_pkg.sv
////////////////////////////////////////
// Shared widths and constants for the save-data and video paths.
// The bridge is fixed big-endian; byte 0 of a word is bits 31:24.
////////////////////////////////////////

package core_pkg;

  // one bridge address or data word
  typedef logic [31:0] bridge_word_t;

  // one byte of save data
  typedef logic [7:0] save_byte_t;

  // pixel, red in the upper byte then green then blue
  typedef logic [23:0] rgb_t;

  // upper nibble of bridge_addr that selects the save region
  localparam logic [3:0] SAVE_REGION = 4'h2;

  localparam int BYTES_PER_WORD = 4;

  // save buffer byte address width, 1 KiB by default
  localparam int DEF_SAVE_ADDR_BITS = 10;

  // cycles between raw hsync edge and the scaler hsync pulse
  localparam int DEF_HS_DELAY = 7;

endpackage
